//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int REG_COUNT = 32;

    typedef logic [31:0]                  word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SYSCALL = 6'h0c,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_SLT     = 6'h2a
    } funct_e;

    // ------------------------------------------------------------
    // Instruction formats
    // ------------------------------------------------------------
    typedef struct packed {
        opcode_e    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [25:0] target;
    } j_fmt_t;

endpackage

`default_nettype wire

//--- mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    // First fetch address after reset
    localparam mips_isa_pkg::word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    // ------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------
    typedef struct packed {
        mips_isa_pkg::word_t instr;
        mips_isa_pkg::word_t pc_plus4;
        logic                valid;
    } if_id_t;

    typedef struct packed {
        alu_op_e                 alu_op;
        mips_isa_pkg::word_t     op_a;
        mips_isa_pkg::word_t     op_b;
        logic [4:0]              shamt;
        mips_isa_pkg::word_t     store_data;
        mips_isa_pkg::reg_addr_t dest;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
        logic                    valid;
    } id_ex_t;

    // A bubble here is an entry with every flag clear
    typedef struct packed {
        mips_isa_pkg::word_t     result;
        mips_isa_pkg::word_t     store_data;
        mips_isa_pkg::reg_addr_t dest;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
    } ex_mem_t;

    typedef struct packed {
        mips_isa_pkg::word_t     data;
        mips_isa_pkg::reg_addr_t dest;
        logic                    en;
    } wb_t;

endpackage

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
    input  logic                    CLK,
    input  logic                    RESET,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    input  mips_pipe_pkg::wb_t      wb,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data
);
    import mips_isa_pkg::*;

    // Entry zero is never written
    word_t regs [REG_COUNT];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through so decode sees a same-cycle write-back
    assign rs_data = (rs_addr == '0)                 ? '0 :
                     (wb.en && wb.dest == rs_addr)   ? wb.data :
                                                       regs[rs_addr];
    assign rt_data = (rt_addr == '0)                 ? '0 :
                     (wb.en && wb.dest == rt_addr)   ? wb.data :
                                                       regs[rt_addr];

    a_zero_reg: assert property (@(posedge CLK) disable iff (!RESET) regs[0] == '0)
        else $error("register zero was written");

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  stall,
    input  logic                  halt,
    input  logic                  redirect,
    input  mips_isa_pkg::word_t   redirect_pc,
    output mips_isa_pkg::word_t   instr_addr,
    input  mips_isa_pkg::word_t   instr_data,
    output mips_pipe_pkg::if_id_t if_id
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t pc;
    word_t pc_plus4;

    assign pc_plus4   = pc + 32'd4;
    assign instr_addr = pc;

    // Redirect lands after the delay slot, which is the word fetched now
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pc    <= RESET_PC;
            if_id <= '0;
        end else if (halt) begin
            if_id <= '0;
        end else if (!stall) begin
            pc             <= redirect ? redirect_pc : pc_plus4;
            if_id.instr    <= instr_data;
            if_id.pc_plus4 <= pc_plus4;
            if_id.valid    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                    CLK,
    input  logic                    RESET,
    input  mips_pipe_pkg::if_id_t   if_id,
    output mips_isa_pkg::reg_addr_t rs_addr,
    output mips_isa_pkg::reg_addr_t rt_addr,
    input  mips_isa_pkg::word_t     rs_data,
    input  mips_isa_pkg::word_t     rt_data,
    input  mips_isa_pkg::reg_addr_t ex_dest,
    input  logic                    ex_reg_write,
    input  mips_isa_pkg::reg_addr_t mem_dest,
    input  logic                    mem_reg_write,
    input  logic                    ex_valid,
    input  logic                    mem_valid,
    output logic                    stall,
    output logic                    redirect,
    output logic                    halt,
    output mips_isa_pkg::word_t     redirect_pc,
    output mips_pipe_pkg::id_ex_t   id_ex,
    output logic                    sys
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    r_fmt_t    r;
    i_fmt_t    i;
    j_fmt_t    j;
    alu_op_e   alu_op;
    reg_addr_t dest;
    logic      use_imm;
    logic      zero_ext;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      uses_rs;
    logic      uses_rt;
    logic      is_beq;
    logic      is_bne;
    logic      is_j;
    logic      is_sys;
    word_t     imm_sext;
    word_t     imm_ext;
    logic      rs_busy;
    logic      rt_busy;
    logic      active;
    logic      go;
    logic      taken;
    logic      halt_q;

    assign r = r_fmt_t'(if_id.instr);
    assign i = i_fmt_t'(if_id.instr);
    assign j = j_fmt_t'(if_id.instr);

    assign rs_addr = r.rs;
    assign rt_addr = r.rt;

    // ------------------------------------------------------------
    // Field decode
    // ------------------------------------------------------------
    always_comb begin
        alu_op    = ALU_ADD;
        dest      = r.rt;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        uses_rs   = 1'b1;
        uses_rt   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        is_sys    = 1'b0;
        case (r.op)
            OP_SPECIAL: begin
                dest      = r.rd;
                use_imm   = 1'b0;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op  = ALU_SLL;
                        uses_rs = 1'b0;
                    end
                    FN_SYSCALL: begin
                        is_sys    = 1'b1;
                        reg_write = 1'b0;
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                    default: begin
                        reg_write = 1'b0;
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: reg_write = 1'b1;
            OP_ANDI: begin
                alu_op    = ALU_AND;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_OR;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
                uses_rs   = 1'b0;
            end
            OP_LW: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                uses_rt   = 1'b1;
            end
            OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            OP_BNE: begin
                is_bne  = 1'b1;
                uses_rt = 1'b1;
            end
            OP_J: begin
                is_j    = 1'b1;
                uses_rs = 1'b0;
            end
            default: uses_rs = 1'b0;
        endcase
    end

    assign imm_sext = {{16{i.imm[15]}}, i.imm};
    assign imm_ext  = zero_ext ? {16'h0000, i.imm} : imm_sext;

    // ------------------------------------------------------------
    // Hazards, redirect and syscall drain
    // ------------------------------------------------------------
    // No forwarding, so any pending writer of a source register blocks decode
    assign rs_busy = (rs_addr != '0) &&
                     ((ex_valid && ex_reg_write && ex_dest == rs_addr) ||
                      (mem_valid && mem_reg_write && mem_dest == rs_addr));
    assign rt_busy = (rt_addr != '0) &&
                     ((ex_valid && ex_reg_write && ex_dest == rt_addr) ||
                      (mem_valid && mem_reg_write && mem_dest == rt_addr));

    assign active = if_id.valid && !halt_q;
    assign stall  = active && ((uses_rs && rs_busy) || (uses_rt && rt_busy));
    assign go     = active && !stall;

    assign taken       = (is_beq && rs_data == rt_data) || (is_bne && rs_data != rt_data);
    assign redirect    = go && (taken || is_j);
    assign redirect_pc = is_j ? {if_id.pc_plus4[31:28], j.target, 2'b00}
                              : if_id.pc_plus4 + {imm_sext[29:0], 2'b00};
    assign halt        = halt_q || (go && is_sys);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            id_ex <= '0;
        end else begin
            id_ex.alu_op     <= alu_op;
            id_ex.op_a       <= rs_data;
            id_ex.op_b       <= use_imm ? imm_ext : rt_data;
            id_ex.shamt      <= r.shamt;
            id_ex.store_data <= rt_data;
            id_ex.dest       <= dest;
            id_ex.reg_write  <= go && reg_write;
            id_ex.mem_read   <= go && mem_read;
            id_ex.mem_write  <= go && mem_write;
            id_ex.valid      <= go;
        end
    end

    // sys waits until execute and memory have drained
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            halt_q <= 1'b0;
            sys    <= 1'b0;
        end else begin
            if (go && is_sys) begin
                halt_q <= 1'b1;
            end
            if (halt_q && !ex_valid && !mem_valid) begin
                sys <= 1'b1;
            end
        end
    end

    a_no_redirect_in_stall: assert property (
        @(posedge CLK) disable iff (!RESET) stall |-> !redirect)
        else $error("redirect during stall");

    a_sys_sticky: assert property (@(posedge CLK) disable iff (!RESET) sys |=> sys)
        else $error("sys dropped before reset");

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                   CLK,
    input  logic                   RESET,
    input  mips_pipe_pkg::id_ex_t  id_ex,
    output mips_pipe_pkg::ex_mem_t ex_mem
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t alu_result;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = id_ex.op_a + id_ex.op_b;
            ALU_SUB: alu_result = id_ex.op_a - id_ex.op_b;
            ALU_AND: alu_result = id_ex.op_a & id_ex.op_b;
            ALU_OR:  alu_result = id_ex.op_a | id_ex.op_b;
            ALU_XOR: alu_result = id_ex.op_a ^ id_ex.op_b;
            // Signed compare
            ALU_SLT: alu_result = {31'd0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
            ALU_SLL: alu_result = id_ex.op_b << id_ex.shamt;
            ALU_LUI: alu_result = {id_ex.op_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ex_mem <= '0;
        end else begin
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= id_ex.store_data;
            ex_mem.dest       <= id_ex.dest;
            // Bubbles leave with every flag clear
            ex_mem.reg_write  <= id_ex.valid && id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.valid && id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.valid && id_ex.mem_write;
        end
    end

    a_rw_exclusive: assert property (
        @(posedge CLK) disable iff (!RESET) id_ex.valid |-> !(id_ex.mem_read && id_ex.mem_write))
        else $error("instruction both loads and stores");

endmodule

`default_nettype wire

//--- memory_stage.sv
`default_nettype none

module memory_stage (
    input  logic                   CLK,
    input  logic                   RESET,
    input  mips_pipe_pkg::ex_mem_t ex_mem,
    output mips_isa_pkg::word_t    mem_addr,
    output logic                   mem_read,
    output logic                   mem_write,
    output mips_isa_pkg::word_t    mem_wdata,
    input  mips_isa_pkg::word_t    mem_rdata,
    output mips_pipe_pkg::wb_t     wb
);

    // Data memory answers in the same cycle
    assign mem_addr  = ex_mem.result;
    assign mem_read  = ex_mem.mem_read;
    assign mem_write = ex_mem.mem_write;
    assign mem_wdata = ex_mem.store_data;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wb <= '0;
        end else begin
            wb.data <= ex_mem.mem_read ? mem_rdata : ex_mem.result;
            wb.dest <= ex_mem.dest;
            wb.en   <= ex_mem.reg_write;
        end
    end

    a_word_aligned: assert property (
        @(posedge CLK) disable iff (!RESET) (mem_read || mem_write) |-> mem_addr[1:0] == 2'b00)
        else $error("unaligned data access at %h", mem_addr);

endmodule

`default_nettype wire

//--- mips_core.sv
`default_nettype none

module mips_core (
    input  logic                CLK,
    input  logic                RESET,
    output mips_isa_pkg::word_t instr_addr,
    input  mips_isa_pkg::word_t instr_data,
    output mips_isa_pkg::word_t mem_addr,
    output logic                mem_read,
    output logic                mem_write,
    output mips_isa_pkg::word_t mem_wdata,
    input  mips_isa_pkg::word_t mem_rdata,
    output logic                sys
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     redirect_pc;
    logic      stall;
    logic      redirect;
    logic      halt;

    fetch_stage fetch_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .stall       (stall),
        .halt        (halt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .if_id       (if_id)
    );

    // ex_mem has no valid bit, a live entry has at least one flag set
    decode_stage decode_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .if_id         (if_id),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ex_dest       (id_ex.dest),
        .ex_reg_write  (id_ex.reg_write),
        .mem_dest      (ex_mem.dest),
        .mem_reg_write (ex_mem.reg_write),
        .ex_valid      (id_ex.valid),
        .mem_valid     (ex_mem.reg_write || ex_mem.mem_read || ex_mem.mem_write),
        .stall         (stall),
        .redirect      (redirect),
        .halt          (halt),
        .redirect_pc   (redirect_pc),
        .id_ex         (id_ex),
        .sys           (sys)
    );

    execute_stage execute_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_stage memory_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .ex_mem    (ex_mem),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .wb        (wb)
    );

    reg_file reg_file_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

`default_nettype wire

//--- tb_mips_mem.sv
`default_nettype none

module tb_mips_mem (
    input  logic                CLK,
    input  mips_isa_pkg::word_t instr_addr,
    output mips_isa_pkg::word_t instr_data,
    input  mips_isa_pkg::word_t mem_addr,
    input  logic                mem_write,
    input  mips_isa_pkg::word_t mem_wdata,
    output mips_isa_pkg::word_t mem_rdata,
    input  logic                clear,
    input  logic                load_en,
    input  mips_isa_pkg::word_t load_addr,
    input  mips_isa_pkg::word_t load_data
);
    import mips_isa_pkg::*;

    localparam int DEPTH = 256;

    word_t imem [DEPTH];
    word_t dmem [DEPTH];

    // Both memories answer in the same cycle
    assign instr_data = imem[instr_addr[9:2]];
    assign mem_rdata  = dmem[mem_addr[9:2]];

    // Untouched data words carry their own byte address
    function automatic word_t fill_value(word_t addr);
        return 32'hc0de_0000 | {22'd0, addr[9:0]};
    endfunction

    function automatic word_t data_at(word_t addr);
        return dmem[addr[9:2]];
    endfunction

    // A load in the clear cycle lands on top of the fill
    always_ff @(posedge CLK) begin
        if (clear) begin
            for (int k = 0; k < DEPTH; k++) begin
                dmem[k] <= fill_value(32'(k * 4));
            end
        end
        if (load_en) begin
            dmem[load_addr[9:2]] <= load_data;
        end else if (mem_write) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // Unused words decode as SYSCALL with the word index as code
    task automatic fill_instr();
        for (int k = 0; k < DEPTH; k++) begin
            imem[k] = {OP_SPECIAL, 12'h000, 8'(k), FN_SYSCALL};
        end
    endtask

    task automatic put_instr(int idx, word_t w);
        imem[idx] = w;
    endtask

endmodule

`default_nettype wire

//--- tb_mips_core.sv
`default_nettype none

module tb_mips_core;
    import mips_isa_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 400;
    localparam int WAIT_LIMIT   = 600;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int ROUNDS       = 20;

    logic  CLK = 1'b0;
    logic  RESET;
    word_t instr_addr;
    word_t instr_data;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_read;
    logic  mem_write;
    logic  sys;
    logic  clear;
    logic  load_en;
    word_t load_addr;
    word_t load_data;
    int    prog_len;
    int    loads_seen;
    int    mismatches;
    int    failures;

    mips_core mips_core_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .sys        (sys)
    );

    tb_mips_mem mem_i (
        .CLK        (CLK),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .mem_addr   (mem_addr),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .clear      (clear),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Data read strobes since the last reset
    always @(posedge CLK) begin
        if (!RESET) begin
            loads_seen <= 0;
        end else if (mem_read) begin
            loads_seen <= loads_seen + 1;
        end
    end

    // ------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------
    function automatic word_t r_word(funct_e fn, int rd, int rs, int rt, int sh);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t i_word(opcode_e op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t j_word(int target);
        return {OP_J, 26'(target >> 2)};
    endfunction

    function automatic word_t store_word(int rt, int addr);
        return i_word(OP_SW, 0, rt, addr);
    endfunction

    function automatic word_t syscall_word();
        return r_word(FN_SYSCALL, 0, 0, 0, 0);
    endfunction

    task automatic emit(word_t w);
        mem_i.put_instr(prog_len, w);
        prog_len++;
    endtask

    task automatic set_reg(int rd, word_t value);
        emit(i_word(OP_LUI, 0, rd, int'(value[31:16])));
        emit(i_word(OP_ORI, rd, rd, int'(value[15:0])));
    endtask

    // ------------------------------------------------------------
    // Program control and checks
    // ------------------------------------------------------------
    // First reset cycle also refills both memories
    task automatic begin_program(
        logic  seed_en   = 1'b0,
        word_t seed_addr = '0,
        word_t seed_data = '0
    );
        @(negedge CLK);
        RESET     = 1'b0;
        clear     = 1'b1;
        load_en   = seed_en;
        load_addr = seed_addr;
        load_data = seed_data;
        prog_len  = 0;
        mem_i.fill_instr();
        @(negedge CLK);
        clear   = 1'b0;
        load_en = 1'b0;
    endtask

    task automatic run_program(string name);
        repeat (RESET_CYCLES - 1) @(negedge CLK);
        RESET = 1'b1;
        for (int c = 0; c < WAIT_LIMIT && !sys; c++) begin
            @(negedge CLK);
        end
        check_sys(name, sys);
    endtask

    task automatic check_word(string name, word_t addr, word_t expected);
        word_t actual;
        actual = mem_i.data_at(addr);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s: addr %h expected %h actual %h",
                     name, addr, expected, actual);
        end
    endtask

    task automatic check_sys(string name, logic level);
        if (level !== 1'b1) begin
            failures++;
            $display("ERROR %s: sys never rose", name);
        end
    endtask

    task automatic check_reads(string name, int expected);
        if (loads_seen != expected) begin
            mismatches++;
            $display("MISMATCH %s: data reads expected %0d actual %0d",
                     name, expected, loads_seen);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic alu_ops();
        word_t a;
        word_t b;
        word_t want [$];
        a = 32'h1234_5678;
        b = 32'hf0f0_00ff;
        begin_program();
        set_reg(1, a);
        set_reg(2, b);
        emit(r_word(FN_ADDU, 3, 1, 2, 0));
        emit(r_word(FN_SUBU, 4, 1, 2, 0));
        emit(r_word(FN_AND, 5, 1, 2, 0));
        emit(r_word(FN_OR, 6, 1, 2, 0));
        emit(r_word(FN_XOR, 7, 1, 2, 0));
        emit(r_word(FN_SLT, 8, 2, 1, 0));
        emit(r_word(FN_SLT, 9, 1, 2, 0));
        emit(r_word(FN_SLL, 10, 0, 1, 4));
        // Sign extension for ADDIU, zero extension for ANDI and ORI
        emit(i_word(OP_ADDIU, 1, 11, -3));
        emit(i_word(OP_ANDI, 2, 12, 'h8f0f));
        emit(i_word(OP_ORI, 1, 13, 'h8000));
        emit(i_word(OP_LUI, 0, 14, 'hbeef));
        for (int k = 3; k <= 14; k++) begin
            emit(store_word(k, k * 4));
        end
        emit(syscall_word());
        run_program("alu_ops");
        want.push_back(a + b);
        want.push_back(a - b);
        want.push_back(a & b);
        want.push_back(a | b);
        want.push_back(a ^ b);
        want.push_back(($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        want.push_back(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        want.push_back(a << 4);
        want.push_back(a + 32'hffff_fffd);
        want.push_back(b & 32'h0000_8f0f);
        want.push_back(a | 32'h0000_8000);
        want.push_back(32'hbeef_0000);
        for (int k = 0; k < 12; k++) begin
            check_word("alu_ops", 32'((k + 3) * 4), want[k]);
        end
        // Stores only, so the read strobe stays low
        check_reads("alu_ops", 0);
    endtask

    task automatic dependent_chains();
        word_t x;
        word_t want [$];
        x = 32'h2468_ace1;
        begin_program();
        set_reg(1, x);
        // Distance one
        emit(r_word(FN_ADDU, 2, 1, 1, 0));
        emit(r_word(FN_ADDU, 3, 2, 1, 0));
        emit(r_word(FN_SUBU, 4, 3, 2, 0));
        emit(i_word(OP_ADDIU, 1, 5, 7));
        emit(i_word(OP_ORI, 0, 6, 3));
        // r5 at distance two
        emit(r_word(FN_XOR, 7, 5, 6, 0));
        emit(i_word(OP_ADDIU, 4, 8, 1));
        emit(r_word(FN_SLL, 0, 0, 0, 0));
        emit(r_word(FN_SLL, 0, 0, 0, 0));
        // Distance three goes through the register file write-through
        emit(r_word(FN_ADDU, 9, 8, 7, 0));
        for (int k = 2; k <= 9; k++) begin
            emit(store_word(k, 'h80 + k * 4));
        end
        emit(syscall_word());
        run_program("dependent_chains");
        want.push_back(x + x);
        want.push_back(x + x + x);
        want.push_back(x);
        want.push_back(x + 32'd7);
        want.push_back(32'd3);
        want.push_back((x + 32'd7) ^ 32'd3);
        want.push_back(x + 32'd1);
        want.push_back((x + 32'd1) + ((x + 32'd7) ^ 32'd3));
        for (int k = 2; k <= 9; k++) begin
            check_word("dependent_chains", 32'('h80 + k * 4), want[k - 2]);
        end
    endtask

    task automatic load_use();
        word_t v;
        v = 32'h0bad_f00d;
        begin_program(1'b1, 32'h40, v);
        emit(i_word(OP_LW, 0, 1, 'h40));
        emit(i_word(OP_ADDIU, 1, 2, 'h123));
        emit(store_word(2, 'h44));
        emit(i_word(OP_LW, 0, 3, 'h40));
        emit(store_word(3, 'h48));
        // Reads back the word just stored, through a base register
        emit(i_word(OP_ADDIU, 0, 4, 'h40));
        emit(i_word(OP_LW, 4, 5, 4));
        emit(i_word(OP_ADDIU, 5, 6, -1));
        emit(store_word(6, 'h4c));
        emit(syscall_word());
        run_program("load_use");
        check_word("load_use", 32'h44, v + 32'h123);
        check_word("load_use", 32'h48, v);
        check_word("load_use", 32'h4c, v + 32'h122);
        // One read strobe per LW
        check_reads("load_use", 3);
    endtask

    task automatic branch_paths();
        word_t mark;
        mark = 32'h0000_00a5;
        begin_program();
        emit(i_word(OP_ADDIU, 0, 1, 5));
        emit(i_word(OP_ADDIU, 0, 2, 5));
        emit(i_word(OP_ADDIU, 0, 3, 6));
        emit(i_word(OP_ADDIU, 0, 10, int'(mark)));
        // Each target sits past the delay slot and one store
        emit(i_word(OP_BEQ, 1, 2, 2));
        emit(store_word(10, 'h100));
        emit(store_word(10, 'h104));
        emit(i_word(OP_BNE, 1, 3, 2));
        emit(store_word(10, 'h108));
        emit(store_word(10, 'h10c));
        emit(i_word(OP_BEQ, 1, 3, 2));
        emit(store_word(10, 'h110));
        emit(store_word(10, 'h114));
        emit(i_word(OP_BNE, 1, 2, 2));
        emit(store_word(10, 'h118));
        emit(store_word(10, 'h11c));
        emit(syscall_word());
        run_program("branch_paths");
        check_word("branch_paths", 32'h100, mark);
        check_word("branch_paths", 32'h104, mem_i.fill_value(32'h104));
        check_word("branch_paths", 32'h108, mark);
        check_word("branch_paths", 32'h10c, mem_i.fill_value(32'h10c));
        for (int k = 0; k < 4; k++) begin
            check_word("branch_paths", 32'('h110 + k * 4), mark);
        end
    endtask

    task automatic jump_and_syscall();
        begin_program();
        emit(i_word(OP_ADDIU, 0, 1, 'h77));
        emit(j_word(16));
        emit(store_word(1, 'h200));
        emit(store_word(1, 'h204));
        emit(i_word(OP_ADDIU, 0, 2, 'h55));
        emit(store_word(2, 'h208));
        emit(syscall_word());
        emit(store_word(2, 'h20c));
        emit(store_word(1, 'h210));
        run_program("jump_and_syscall");
        // Older store must already be in memory when sys is seen
        check_word("jump_and_syscall", 32'h208, 32'h55);
        repeat (10) @(negedge CLK);
        check_word("jump_and_syscall", 32'h200, 32'h77);
        check_word("jump_and_syscall", 32'h204, mem_i.fill_value(32'h204));
        check_word("jump_and_syscall", 32'h20c, mem_i.fill_value(32'h20c));
        check_word("jump_and_syscall", 32'h210, mem_i.fill_value(32'h210));
    endtask

    task automatic random_rounds();
        word_t a [ROUNDS];
        word_t b [ROUNDS];
        word_t base;
        begin_program();
        for (int n = 0; n < ROUNDS; n++) begin
            a[n] = $urandom();
            b[n] = $urandom();
            set_reg(1, a[n]);
            set_reg(2, b[n]);
            emit(r_word(FN_ADDU, 3, 1, 2, 0));
            emit(r_word(FN_SUBU, 4, 1, 2, 0));
            emit(r_word(FN_XOR, 5, 1, 2, 0));
            emit(r_word(FN_SLT, 6, 1, 2, 0));
            for (int k = 0; k < 4; k++) begin
                emit(store_word(3 + k, n * 16 + k * 4));
            end
        end
        emit(syscall_word());
        run_program("random_rounds");
        for (int n = 0; n < ROUNDS; n++) begin
            base = 32'(n * 16);
            check_word("random_rounds", base, a[n] + b[n]);
            check_word("random_rounds", base + 32'd4, a[n] - b[n]);
            check_word("random_rounds", base + 32'd8, a[n] ^ b[n]);
            check_word("random_rounds", base + 32'd12,
                       ($signed(a[n]) < $signed(b[n])) ? 32'd1 : 32'd0);
        end
    endtask

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("ERROR watchdog: tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        RESET      = 1'b0;
        clear      = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        prog_len   = 0;
        mismatches = 0;
        failures   = 0;
        void'($urandom(32'hbd25_7b7d));
        alu_ops();
        dependent_chains();
        load_use();
        branch_paths();
        jump_and_syscall();
        random_rounds();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_mem.sv
tb_mips_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_mips_core
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
